//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // ------------------------------------------------------------------
    // Widths and burst shape.
    // ------------------------------------------------------------------
    localparam int ADDR_W    = 32;
    localparam int BEAT_W    = 64;
    localparam int BURST_LEN = 4;
    localparam int LINE_W    = BEAT_W * BURST_LEN;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [BEAT_W-1:0] beat_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [1:0]        beat_idx_t;

    // Index of the final beat in a burst.
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(BURST_LEN - 1);

    // ------------------------------------------------------------------
    // Port bundles.
    // ------------------------------------------------------------------
    // Cache side request, held steady until the response.
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        line_t wdata;
    } dfp_req_t;

    // One beat returned by the burst memory.
    typedef struct packed {
        logic  rvalid;
        addr_t raddr;
        beat_t rdata;
    } bmem_rd_t;

endpackage

`default_nettype wire

//--- source/burst_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

module burst_deserializer (
    input  logic              clk,
    input  logic              rst,

    input  logic              bmem_ready,
    input  mem_pkg::bmem_rd_t bmem_rd,
    input  logic              wr_active,
    input  mem_pkg::line_t    wr_line,

    output logic              bmem_write,
    output mem_pkg::beat_t    bmem_wdata,
    output logic              line_done,
    output mem_pkg::line_t    dfp_rdata,
    output mem_pkg::addr_t    dfp_raddr
);
    import mem_pkg::*;

    beat_idx_t rd_cnt;
    beat_idx_t wr_cnt;
    line_t     rd_line;
    line_t     rd_line_next;
    logic      rd_accept;
    logic      wr_accept;

    // ------------------------------------------------------------------
    // Read path.
    // ------------------------------------------------------------------
    assign rd_accept = bmem_rd.rvalid && bmem_ready;

    // Partial line with the incoming beat dropped into its slot.
    always_comb begin
        rd_line_next = rd_line;
        rd_line_next[rd_cnt*BEAT_W +: BEAT_W] = bmem_rd.rdata;
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_line <= rd_line_next;
        end
    end

    // ------------------------------------------------------------------
    // Write path.
    // ------------------------------------------------------------------
    // The beat after the last one is held off while line_done is out,
    // since the sequencer only drops wr_active a cycle later.
    assign bmem_write = wr_active && !line_done;
    assign wr_accept  = bmem_write && bmem_ready;
    assign bmem_wdata = wr_line[wr_cnt*BEAT_W +: BEAT_W];

    // ------------------------------------------------------------------
    // Counters and completion.
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cnt    <= '0;
            wr_cnt    <= '0;
            line_done <= 1'b0;
            dfp_rdata <= '0;
            dfp_raddr <= '0;
        end else begin
            line_done <= 1'b0;

            if (rd_accept) begin
                rd_cnt <= rd_cnt + 1'b1;
                // Fourth beat completes the line.
                if (rd_cnt == LAST_BEAT) begin
                    dfp_rdata <= rd_line_next;
                    dfp_raddr <= bmem_rd.raddr;
                    line_done <= 1'b1;
                end
            end

            if (wr_accept) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (wr_cnt == LAST_BEAT) begin
                    line_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/bmem_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module bmem_sequencer (
    input  logic              clk,
    input  logic              rst,

    input  mem_pkg::dfp_req_t dfp_req,
    input  logic              bmem_ready,
    input  logic              line_done,

    output mem_pkg::addr_t    bmem_addr,
    output logic              bmem_read,
    output logic              wr_active,
    output logic              dfp_resp
);

    typedef enum logic [2:0] {
        IDLE,
        RD_CMD,
        RD_WAIT,
        WR_BURST,
        RESP
    } state_t;

    state_t state;
    state_t state_next;
    logic   req_start;

    assign req_start = (state == IDLE) && (dfp_req.read || dfp_req.write);

    // ------------------------------------------------------------------
    // Next state.
    // ------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (dfp_req.read) begin
                    state_next = RD_CMD;
                end else if (dfp_req.write) begin
                    state_next = WR_BURST;
                end
            end
            RD_CMD: begin
                // Command is taken once the memory is ready.
                if (bmem_ready) begin
                    state_next = RD_WAIT;
                end
            end
            RD_WAIT: begin
                if (line_done) begin
                    state_next = RESP;
                end
            end
            WR_BURST: begin
                if (line_done) begin
                    state_next = RESP;
                end
            end
            RESP: begin
                // Request is still held here, so go back without sampling it.
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ------------------------------------------------------------------
    // Address and outputs.
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            bmem_addr <= '0;
        end else if (req_start) begin
            bmem_addr <= dfp_req.addr;
        end
    end

    assign bmem_read = (state == RD_CMD);
    assign wr_active = (state == WR_BURST);
    assign dfp_resp  = (state == RESP);

endmodule

`default_nettype wire

//--- source/cache_mem_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module cache_mem_bridge (
    input  logic              clk,
    input  logic              rst,

    // Cache line port.
    input  mem_pkg::dfp_req_t dfp_req,
    output mem_pkg::line_t    dfp_rdata,
    output mem_pkg::addr_t    dfp_raddr,
    output logic              dfp_resp,

    // Burst memory port.
    input  logic              bmem_ready,
    input  mem_pkg::bmem_rd_t bmem_rd,
    output mem_pkg::addr_t    bmem_addr,
    output logic              bmem_read,
    output logic              bmem_write,
    output mem_pkg::beat_t    bmem_wdata
);

    logic wr_active;
    logic line_done;

    // ------------------------------------------------------------------
    // Command and response control.
    // ------------------------------------------------------------------
    bmem_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .dfp_req    (dfp_req),
        .bmem_ready (bmem_ready),
        .line_done  (line_done),
        .bmem_addr  (bmem_addr),
        .bmem_read  (bmem_read),
        .wr_active  (wr_active),
        .dfp_resp   (dfp_resp)
    );

    // ------------------------------------------------------------------
    // Beat assembly and split.
    // ------------------------------------------------------------------
    burst_deserializer u_deserializer (
        .clk        (clk),
        .rst        (rst),
        .bmem_ready (bmem_ready),
        .bmem_rd    (bmem_rd),
        .wr_active  (wr_active),
        .wr_line    (dfp_req.wdata),
        .bmem_write (bmem_write),
        .bmem_wdata (bmem_wdata),
        .line_done  (line_done),
        .dfp_rdata  (dfp_rdata),
        .dfp_raddr  (dfp_raddr)
    );

endmodule

`default_nettype wire

//--- tb/bmem_model.sv
`timescale 1ns/1ns
`default_nettype none

module bmem_model (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::addr_t    bmem_addr,
    input  logic              bmem_read,
    input  logic              bmem_write,
    input  mem_pkg::beat_t    bmem_wdata,
    output logic              bmem_ready,
    output mem_pkg::bmem_rd_t bmem_rd
);
    import mem_pkg::*;

    beat_t mem [addr_t];
    addr_t rd_addr;
    int    rd_left;
    int    rd_beat;
    int    wr_beat;

    // Untouched memory reads back a value built from every address bit.
    function automatic beat_t init_beat(addr_t a);
        return {a ^ 32'h5A5A_C3C3, ~a};
    endfunction

    function automatic beat_t read_beat(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return init_beat(a);
    endfunction

    initial begin
        bmem_ready = 1'b0;
        bmem_rd    = '0;
        rd_addr    = '0;
        rd_left    = 0;
        rd_beat    = 0;
        wr_beat    = 0;
    end

    // Accepts are taken mid-cycle.
    // New ready and beats go out just after the edge.
    always begin
        @(negedge clk);
        if (rst) begin
            rd_left = 0;
            rd_beat = 0;
            wr_beat = 0;
        end else begin
            if (bmem_rd.rvalid && bmem_ready) begin
                rd_left = rd_left - 1;
                rd_beat = rd_beat + 1;
            end
            if (bmem_read && bmem_ready) begin
                rd_addr = bmem_addr;
                rd_left = BURST_LEN;
                rd_beat = 0;
            end
            if (bmem_write && bmem_ready) begin
                mem[bmem_addr + addr_t'(8 * wr_beat)] = bmem_wdata;
                wr_beat = (wr_beat + 1) % BURST_LEN;
            end
        end
        @(posedge clk);
        #1;
        bmem_ready = !rst && (($urandom % 4) != 0);
        bmem_rd    = '0;
        if (!rst && rd_left > 0 && ($urandom % 3) != 0) begin
            bmem_rd.rvalid = 1'b1;
            bmem_rd.raddr  = rd_addr;
            bmem_rd.rdata  = read_beat(rd_addr + addr_t'(8 * rd_beat));
        end
    end

endmodule

`default_nettype wire

//--- tb/bridge_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module bridge_monitor (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::dfp_req_t dfp_req,
    input  logic              dfp_resp,
    input  mem_pkg::line_t    dfp_rdata,
    input  mem_pkg::addr_t    dfp_raddr,
    input  logic              bmem_read,
    input  logic              bmem_write,
    input  mem_pkg::line_t    exp_rdata,
    output int                error_count,
    output int                resp_count
);
    import mem_pkg::*;

    logic pending;

    initial begin
        error_count = 0;
        resp_count  = 0;
    end

    // Sampled on the falling edge, where every DUT output has settled.
    always @(negedge clk) begin
        pending = dfp_req.read || dfp_req.write;
        if (!rst) begin
            if (!pending && (dfp_resp || bmem_read || bmem_write)) begin
                $display("Activity on the bridge at %0t with no request outstanding", $time);
                error_count = error_count + 1;
            end
            if (dfp_resp && pending) begin
                resp_count = resp_count + 1;
                if (dfp_req.read && dfp_rdata !== exp_rdata) begin
                    $display("[ERROR] %0t dfp_rdata expected %h got %h",
                             $time, exp_rdata, dfp_rdata);
                    error_count = error_count + 1;
                end
                if (dfp_req.read && dfp_raddr !== dfp_req.addr) begin
                    $display("[ERROR] %0t dfp_raddr expected %h got %h",
                             $time, dfp_req.addr, dfp_raddr);
                    error_count = error_count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/bridge_chk.sv
`timescale 1ns/1ns
`default_nettype none

module bridge_chk (
    input  logic           clk,
    input  logic           rst,
    input  logic           bmem_ready,
    input  logic           bmem_read,
    input  logic           bmem_write,
    input  mem_pkg::addr_t bmem_addr,
    input  mem_pkg::beat_t bmem_wdata,
    input  logic           dfp_resp
);

    a_cmd_excl: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read && bmem_write))
        else $error("bmem_read and bmem_write high together");

    a_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        dfp_resp |=> !dfp_resp)
        else $error("dfp_resp longer than one cycle");

    // A stalled command or beat stays put.
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (bmem_read || bmem_write) && !bmem_ready |=>
            $stable(bmem_read) && $stable(bmem_write) &&
            $stable(bmem_addr) && $stable(bmem_wdata))
        else $error("memory port changed while stalled");

endmodule

`default_nettype wire

//--- tb/tb_cache_mem_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cache_mem_bridge;
    import mem_pkg::*;

    typedef struct packed {
        logic  is_write;
        addr_t addr;
        line_t wdata;
    } op_t;

    logic     clk = 1'b0;
    logic     rst;
    dfp_req_t dfp_req;
    line_t    dfp_rdata;
    addr_t    dfp_raddr;
    logic     dfp_resp;
    logic     bmem_ready;
    bmem_rd_t bmem_rd;
    addr_t    bmem_addr;
    logic     bmem_read;
    logic     bmem_write;
    beat_t    bmem_wdata;
    line_t    exp_rdata;
    int       mon_errors;
    int       resp_count;
    int       tb_errors;
    op_t      ops[$];
    line_t    shadow [addr_t];

    always #4 clk = ~clk;

    cache_mem_bridge UUT (
        .clk(clk), .rst(rst), .dfp_req(dfp_req), .dfp_rdata(dfp_rdata),
        .dfp_raddr(dfp_raddr), .dfp_resp(dfp_resp), .bmem_ready(bmem_ready),
        .bmem_rd(bmem_rd), .bmem_addr(bmem_addr), .bmem_read(bmem_read),
        .bmem_write(bmem_write), .bmem_wdata(bmem_wdata)
    );

    bmem_model u_mem (
        .clk(clk), .rst(rst), .bmem_addr(bmem_addr), .bmem_read(bmem_read),
        .bmem_write(bmem_write), .bmem_wdata(bmem_wdata),
        .bmem_ready(bmem_ready), .bmem_rd(bmem_rd)
    );

    bridge_monitor u_mon (
        .clk(clk), .rst(rst), .dfp_req(dfp_req), .dfp_resp(dfp_resp),
        .dfp_rdata(dfp_rdata), .dfp_raddr(dfp_raddr), .bmem_read(bmem_read),
        .bmem_write(bmem_write), .exp_rdata(exp_rdata),
        .error_count(mon_errors), .resp_count(resp_count)
    );

    bind cache_mem_bridge bridge_chk u_chk (
        .clk(clk), .rst(rst), .bmem_ready(bmem_ready), .bmem_read(bmem_read),
        .bmem_write(bmem_write), .bmem_addr(bmem_addr),
        .bmem_wdata(bmem_wdata), .dfp_resp(dfp_resp)
    );

    // Memory starting value, beat 0 in the low bits.
    function automatic line_t start_line(addr_t a);
        line_t l;
        addr_t b;
        for (int k = 0; k < BURST_LEN; k++) begin
            b = a + addr_t'(8 * k);
            l[k*64 +: 64] = {b ^ 32'h5A5A_C3C3, ~b};
        end
        return l;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int k = 0; k < 8; k++) begin
            l[k*32 +: 32] = $urandom;
        end
        return l;
    endfunction

    task automatic add_op(input logic is_write, input addr_t addr);
        op_t op;
        op.is_write = is_write;
        op.addr     = addr;
        op.wdata    = is_write ? random_line() : '0;
        ops.push_back(op);
    endtask

    task automatic wait_resp(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < 200 && !seen; n++) begin
            @(negedge clk);
            seen = dfp_resp;
        end
    endtask

    initial begin
        bit seen;
        bit timed_out;
        void'($urandom(75215));
        rst       = 1'b1;
        dfp_req   = '0;
        exp_rdata = '0;
        tb_errors = 0;
        timed_out = 1'b0;

        // Stimulus table.
        add_op(1'b0, 32'h0000_1000);
        add_op(1'b1, 32'h0000_2000);
        add_op(1'b0, 32'h0000_2000);
        add_op(1'b1, 32'h0000_3000);
        add_op(1'b1, 32'h0000_3020);
        add_op(1'b1, 32'h0000_3040);
        add_op(1'b0, 32'h0000_3040);
        add_op(1'b0, 32'h0000_3000);
        add_op(1'b0, 32'h0000_3020);
        add_op(1'b0, 32'h0000_1020);
        add_op(1'b1, 32'h0000_3000);
        add_op(1'b0, 32'h0000_3000);

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < ops.size() && !timed_out; i++) begin
            @(posedge clk);
            #1;
            exp_rdata = shadow.exists(ops[i].addr) ? shadow[ops[i].addr]
                                                   : start_line(ops[i].addr);
            dfp_req.read  = !ops[i].is_write;
            dfp_req.write = ops[i].is_write;
            dfp_req.addr  = ops[i].addr;
            dfp_req.wdata = ops[i].wdata;
            wait_resp(seen);
            if (!seen) begin
                $display("Timed out waiting for dfp_resp on entry %0d", i);
                tb_errors = tb_errors + 1;
                timed_out = 1'b1;
            end else begin
                if (ops[i].is_write) begin
                    shadow[ops[i].addr] = ops[i].wdata;
                end
                // Port goes idle for a cycle between requests.
                @(posedge clk);
                #1;
                dfp_req = '0;
            end
        end

        @(posedge clk);
        #1;
        dfp_req = '0;
        repeat (5) @(posedge clk);

        if (resp_count != ops.size()) begin
            $display("Saw %0d responses for %0d requests", resp_count, ops.size());
            tb_errors = tb_errors + 1;
        end
        $display("Monitor errors: %0d, testbench errors: %0d, responses: %0d",
                 mon_errors, tb_errors, resp_count);
        if (mon_errors == 0 && tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/mem_pkg.sv
source/burst_deserializer.sv
source/bmem_sequencer.sv
source/cache_mem_bridge.sv
tb/bmem_model.sv
tb/bridge_monitor.sv
tb/bridge_chk.sv
tb/tb_cache_mem_bridge.sv

//--- Makefile
TOP = tb_cache_mem_bridge

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
